/* logic/alu.sv */
// --------------------
// 8-bit add/subtract and logic unit
// --------------------
`timescale 1ns/1ps

module alu import cpuPkg::*; (
  input  aluOpT      aluOp,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  logic       carryIn,
  output logic [7:0] result,
  output logic       carryOut,
  output logic       overflow,
  output logic       zero,
  output logic       negative
);

  logic [7:0] addend;
  logic [8:0] sum;

  // SBC is A + ~B + C, carry set means no borrow
  assign addend = (aluOp == aluSub) ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, addend} + {8'd0, carryIn};

  always_comb begin
    result   = b;
    carryOut = carryIn;
    overflow = 1'b0;
    case (aluOp)
      aluAdd, aluSub: begin
        result   = sum[7:0];
        carryOut = sum[8];
        // operands of equal sign giving a result of the other sign
        overflow = (a[7] == addend[7]) && (sum[7] != a[7]);
      end
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluEor:  result = a ^ b;
      default: result = b;
    endcase
  end

  assign zero     = (result == 8'd0);
  assign negative = result[7];

endmodule

/* logic/busMaster.sv */
// --------------------
// Wishbone classic master, one access per request
// --------------------
`timescale 1ns/1ps

module busMaster import busPkg::*; #(
  parameter int ADDR_WIDTH = busPkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = busPkg::DATA_WIDTH
) (
  input  logic                  phi2,
  input  logic                  arstN,
  input  logic                  reqValid,
  input  logic [ADDR_WIDTH-1:0] reqAddr,
  input  logic                  reqWrite,
  input  logic [DATA_WIDTH-1:0] reqData,
  input  logic                  wbAck,
  input  logic [DATA_WIDTH-1:0] wbDatI,
  output logic                  rspDone,
  output logic [DATA_WIDTH-1:0] rspData,
  output logic                  wbCyc,
  output logic                  wbStb,
  output logic                  wbWe,
  output logic [ADDR_WIDTH-1:0] wbAdr,
  output logic [DATA_WIDTH-1:0] wbDatO
);

  busStateT state;
  logic     accept;
  logic     finish;

  assign accept = (state == busIdle) && reqValid;
  assign finish = (state == busActive) && wbAck;

  // cyc and stb follow the state, dropping the cycle after ack
  assign wbCyc = (state == busActive);
  assign wbStb = (state == busActive);

  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      state   <= busIdle;
      wbWe    <= 1'b0;
      rspDone <= 1'b0;
    end else begin
      rspDone <= finish;
      if (accept) begin
        state <= busActive;
        wbWe  <= reqWrite;
      end else if (finish) begin
        state <= busIdle;
        wbWe  <= 1'b0;
      end
    end
  end

  always_ff @(posedge phi2) begin
    if (accept) begin
      wbAdr  <= reqAddr;
      wbDatO <= reqData;
    end
    if (finish) begin
      rspData <= wbDatI;
    end
  end

endmodule

/* logic/busPkg.sv */
// --------------------
// bus widths, bus-cycle states and reset vector
// --------------------
package busPkg;

  // defaults, the top level passes the real widths down
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 8;

  typedef enum logic [1:0] {busIdle, busActive} busStateT;

  // low byte of the vector, high byte follows
  localparam logic [15:0] RESET_VECTOR = 16'hFFFC;

endpackage

/* logic/controlFsm.sv */
// --------------------
// instruction sequencer: vector, fetch, operands, execute
// owns the program counter and the operand latch
// --------------------
`timescale 1ns/1ps

module controlFsm import cpuPkg::*, busPkg::*; (
  input  logic        phi2,
  input  logic        arstN,
  input  logic        rspDone,
  input  logic [7:0]  rspData,
  input  addrModeT    addrMode,
  input  logic        storeAcc,
  input  logic        loadAcc,
  input  logic        isJump,
  input  logic [7:0]  acc,
  output logic        reqValid,
  output logic [15:0] reqAddr,
  output logic        reqWrite,
  output logic [7:0]  reqData,
  output logic [7:0]  opcode,
  output logic [7:0]  operand,
  output logic [15:0] pc,
  output logic        execStrobe,
  output logic        accLoad,
  output logic        sync
);

  cpuStateT   state;
  logic       reqPending;
  logic       needBus;
  logic [7:0] opLo, opHi;

  always_comb begin
    case (state)
      stOperand: needBus = (addrMode != modeImplied);
      stExec:    needBus = 1'b0;
      default:   needBus = 1'b1;
    endcase
  end

  // one request per bus state, then wait for the answer
  assign reqValid = needBus && !reqPending;
  assign reqWrite = (state == stStore);
  assign reqData  = acc;
  assign sync     = reqValid && (state == stFetch);

  always_comb begin
    case (state)
      stVecLo:         reqAddr = RESET_VECTOR;
      stVecHi:         reqAddr = RESET_VECTOR + 16'd1;
      stLoad, stStore: reqAddr = {opHi, opLo};
      default:         reqAddr = pc;
    endcase
  end

  assign operand    = opLo;
  assign execStrobe = (state == stExec);
  assign accLoad    = execStrobe && loadAcc;

  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      state      <= stVecLo;
      reqPending <= 1'b0;
      pc         <= 16'd0;
      opcode     <= 8'd0;
    end else begin
      if (reqValid) begin
        reqPending <= 1'b1;
      end else if (rspDone) begin
        reqPending <= 1'b0;
      end
      case (state)
        stVecLo: if (rspDone) state <= stVecHi;
        stVecHi: if (rspDone) begin
          pc    <= {rspData, opLo};
          state <= stFetch;
        end
        stFetch: if (rspDone) begin
          opcode <= rspData;
          pc     <= pc + 16'd1;
          state  <= stOperand;
        end
        stOperand: begin
          if (addrMode == modeImplied) begin
            state <= stExec;
          end else if (rspDone) begin
            pc    <= pc + 16'd1;
            state <= (addrMode == modeImmediate) ? stExec : stAddrHi;
          end
        end
        stAddrHi: if (rspDone) begin
          if (isJump) begin
            pc    <= {rspData, opLo};
            state <= stFetch;
          end else begin
            pc    <= pc + 16'd1;
            state <= storeAcc ? stStore : stLoad;
          end
        end
        stLoad:  if (rspDone) state <= stExec;
        stStore: if (rspDone) state <= stFetch;
        default: state <= stFetch;
      endcase
    end
  end

  // operand latch, the loaded byte replaces the low address
  always_ff @(posedge phi2) begin
    if (rspDone) begin
      case (state)
        stVecLo, stOperand, stLoad: opLo <= rspData;
        stAddrHi:                   opHi <= rspData;
        default:                    ;
      endcase
    end
  end

endmodule

/* logic/cpuPkg.sv */
// --------------------
// opcodes, ALU operations, FSM states and flag positions
// shared by decode, ALU, status register and sequencer
// --------------------
package cpuPkg;

  // real 6502 encodings of the supported subset
  typedef enum logic [7:0] {
    opLdaImm = 8'hA9,
    opLdaAbs = 8'hAD,
    opStaAbs = 8'h8D,
    opAdcImm = 8'h69,
    opSbcImm = 8'hE9,
    opAndImm = 8'h29,
    opOraImm = 8'h09,
    opEorImm = 8'h49,
    opJmpAbs = 8'h4C,
    opSec    = 8'h38,
    opClc    = 8'h18,
    opNop    = 8'hEA
  } opcodeT;

  typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluOr, aluEor} aluOpT;

  typedef enum logic [3:0] {
    stVecLo, stVecHi, stFetch, stOperand, stAddrHi, stExec, stLoad, stStore
  } cpuStateT;

  typedef enum logic [1:0] {modeImplied, modeImmediate, modeAbsolute} addrModeT;

  // P register layout
  localparam int flagC = 0;
  localparam int flagZ = 1;
  localparam int flagV = 6;
  localparam int flagN = 7;

endpackage

/* logic/cpuTop.sv */
// --------------------
// 6502 subset core on a Wishbone classic bus
// --------------------
`timescale 1ns/1ps

module cpuTop import cpuPkg::*, busPkg::*; #(
  parameter int ADDR_WIDTH = busPkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = busPkg::DATA_WIDTH
) (
  input  logic                  phi2,
  input  logic                  arstN,
  input  logic                  wbAck,
  input  logic [DATA_WIDTH-1:0] wbDatI,
  output logic                  wbCyc,
  output logic                  wbStb,
  output logic                  wbWe,
  output logic [ADDR_WIDTH-1:0] wbAdr,
  output logic [DATA_WIDTH-1:0] wbDatO,
  output logic                  sync
);

  logic        reqValid, reqWrite, rspDone;
  logic [15:0] reqAddr;
  logic [7:0]  reqData, rspData;
  logic [7:0]  opcode, operand, acc, flags;
  logic        execStrobe, accLoad;
  aluOpT       aluOp;
  addrModeT    addrMode;
  logic        loadAcc, storeAcc, isJump, setCarry, clrCarry, updNz, updCv;
  logic [7:0]  aluResult;
  logic        aluCarry, aluOverflow, aluZero, aluNegative;

  // accumulator
  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      acc <= 8'd0;
    end else if (accLoad) begin
      acc <= aluResult;
    end
  end

  controlFsm fsm (
    .phi2, .arstN, .rspDone, .rspData, .addrMode, .storeAcc, .loadAcc, .isJump, .acc,
    .reqValid, .reqAddr, .reqWrite, .reqData, .opcode, .operand,
    .pc(), .execStrobe, .accLoad, .sync
  );

  instructionDecode decode (
    .opcode, .aluOp, .addrMode, .loadAcc, .storeAcc, .isJump,
    .setCarry, .clrCarry, .updNz, .updCv
  );

  alu aluUnit (
    .aluOp, .a(acc), .b(operand), .carryIn(flags[flagC]),
    .result(aluResult), .carryOut(aluCarry), .overflow(aluOverflow),
    .zero(aluZero), .negative(aluNegative)
  );

  statusReg status (
    .phi2, .arstN, .updNz, .updCv, .setCarry, .clrCarry,
    .carryIn(aluCarry), .overflowIn(aluOverflow), .zeroIn(aluZero),
    .negativeIn(aluNegative), .load(execStrobe), .flags
  );

  busMaster #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bus (
    .phi2, .arstN, .reqValid, .reqAddr, .reqWrite, .reqData, .wbAck, .wbDatI,
    .rspDone, .rspData, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatO
  );

endmodule

/* logic/instructionDecode.sv */
// --------------------
// opcode to datapath controls, combinational
// --------------------
`timescale 1ns/1ps

module instructionDecode import cpuPkg::*; (
  input  logic [7:0] opcode,
  output aluOpT      aluOp,
  output addrModeT   addrMode,
  output logic       loadAcc,
  output logic       storeAcc,
  output logic       isJump,
  output logic       setCarry,
  output logic       clrCarry,
  output logic       updNz,
  output logic       updCv
);

  always_comb begin
    // anything unlisted falls through as an implied NOP
    aluOp    = aluPass;
    addrMode = modeImplied;
    loadAcc  = 1'b0;
    storeAcc = 1'b0;
    isJump   = 1'b0;
    setCarry = 1'b0;
    clrCarry = 1'b0;
    updCv    = 1'b0;
    case (opcode)
      opLdaImm: begin addrMode = modeImmediate; loadAcc = 1'b1; end
      opLdaAbs: begin addrMode = modeAbsolute;  loadAcc = 1'b1; end
      opStaAbs: begin addrMode = modeAbsolute;  storeAcc = 1'b1; end
      opJmpAbs: begin addrMode = modeAbsolute;  isJump = 1'b1; end
      opAdcImm: begin
        addrMode = modeImmediate;
        aluOp    = aluAdd;
        loadAcc  = 1'b1;
        updCv    = 1'b1;
      end
      opSbcImm: begin
        addrMode = modeImmediate;
        aluOp    = aluSub;
        loadAcc  = 1'b1;
        updCv    = 1'b1;
      end
      opAndImm: begin addrMode = modeImmediate; aluOp = aluAnd; loadAcc = 1'b1; end
      opOraImm: begin addrMode = modeImmediate; aluOp = aluOr;  loadAcc = 1'b1; end
      opEorImm: begin addrMode = modeImmediate; aluOp = aluEor; loadAcc = 1'b1; end
      opSec:    setCarry = 1'b1;
      opClc:    clrCarry = 1'b1;
      default:  ;
    endcase
    // every accumulator write also sets N and Z, as on a real 6502
    updNz = loadAcc;
  end

endmodule

/* logic/statusReg.sv */
// --------------------
// N V Z C flags in P register layout
// --------------------
`timescale 1ns/1ps

module statusReg import cpuPkg::*; (
  input  logic       phi2,
  input  logic       arstN,
  input  logic       updNz,
  input  logic       updCv,
  input  logic       setCarry,
  input  logic       clrCarry,
  input  logic       carryIn,
  input  logic       overflowIn,
  input  logic       zeroIn,
  input  logic       negativeIn,
  input  logic       load,
  output logic [7:0] flags
);

  logic n, v, z, c;

  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      n <= 1'b0;
      v <= 1'b0;
      z <= 1'b0;
      c <= 1'b0;
    end else if (load) begin
      if (updNz) begin
        n <= negativeIn;
        z <= zeroIn;
      end
      if (updCv) begin
        v <= overflowIn;
      end
      // SEC/CLC win over an arithmetic carry
      if (setCarry) begin
        c <= 1'b1;
      end else if (clrCarry) begin
        c <= 1'b0;
      end else if (updCv) begin
        c <= carryIn;
      end
    end
  end

  always_comb begin
    // bits 5 and 4 read as 1 like a pushed P image
    flags        = 8'h30;
    flags[flagN] = n;
    flags[flagV] = v;
    flags[flagZ] = z;
    flags[flagC] = c;
  end

endmodule

/* project.f */
logic/busPkg.sv
logic/cpuPkg.sv
logic/instructionDecode.sv
logic/alu.sv
logic/statusReg.sv
logic/controlFsm.sv
logic/busMaster.sv
logic/cpuTop.sv
testbench/wbMemoryModel.sv
testbench/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpuTb -Mdir obj_dir -f project.f

output="$(./obj_dir/VcpuTb)"
echo "$output"

if grep -q "STATUS: PASS" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* testbench/cpuTb.sv */
// --------------------
// random programs run on cpuTop
// stores compared with a software reference model
// --------------------
`timescale 1ns/1ps

module cpuTb;

  logic        clk;
  logic        arstN;
  logic        wbCyc, wbStb, wbWe, wbAck, sync;
  logic [15:0] wbAdr;
  logic [7:0]  wbDatO, wbDatI;
  logic [1:0]  ackDelay;
  logic        randomDelays;

  logic [7:0]  img [0:65535];
  logic [15:0] pcW, progStart, endAddr, storeAddr;
  logic [31:0] progLfsr, delayLfsr;
  logic [15:0] expAddr[$];
  logic [7:0]  expData[$];
  logic        loopSeen, syncPending, syncChecked, prevStb, prevAck;
  int          accessIdx;
  int          dataErrors, protocolErrors, timeouts;

  cpuTop #(.ADDR_WIDTH(16), .DATA_WIDTH(8)) uut (
    .phi2(clk), .arstN, .wbAck, .wbDatI,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatO, .sync
  );

  wbMemoryModel memory (
    .clk, .arstN, .ackDelay, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatO, .wbAck, .wbDatI
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randProg(input int bits);
    logic [31:0] r;
    r = 32'd0;
    for (int i = 0; i < bits; i++) begin
      progLfsr = lfsrNext(progLfsr);
      r = {r[30:0], progLfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [1:0] randDelay();
    delayLfsr = lfsrNext(delayLfsr);
    delayLfsr = lfsrNext(delayLfsr);
    return delayLfsr[1:0];
  endfunction

  always @(posedge clk) begin
    ackDelay <= randomDelays ? randDelay() : 2'd0;
  end

  task automatic emit(input logic [7:0] b);
    img[pcW] = b;
    pcW = pcW + 16'd1;
  endtask

  task automatic emitAbs(input logic [7:0] op, input logic [15:0] addr);
    emit(op);
    emit(addr[7:0]);
    emit(addr[15:8]);
  endtask

  task automatic emitStore();
    emitAbs(8'h8D, storeAddr);
    storeAddr = storeAddr + 16'd1;
  endtask

  task automatic buildProgram();
    logic [15:0] a16, target;
    logic [2:0]  kind;
    int          sinceStore, gap;
    for (int i = 0; i < 65536; i++) begin
      a16 = 16'(i);
      img[i] = a16[7:0] ^ a16[15:8] ^ 8'h5A;
    end
    progStart = 16'h0200 | {4'd0, 3'(randProg(3)), 9'd0};
    pcW = progStart;
    storeAddr = 16'h4000;
    sinceStore = 0;
    for (int i = 0; i < 30; i++) begin
      kind = 3'(randProg(3));
      case (kind)
        3'd0: begin
          emit(8'hA9);
          emit(8'(randProg(8)));
        end
        3'd1: emitAbs(8'hAD, {8'h30, 8'(randProg(8))});
        3'd2, 3'd3: begin
          emit(randProg(1) == 32'd1 ? 8'h38 : 8'h18);
          emit(kind == 3'd2 ? 8'h69 : 8'hE9);
          emit(8'(randProg(8)));
          emitStore();
          // carry made visible through ADC #0
          emit(8'hA9);
          emit(8'h00);
          emit(8'h69);
          emit(8'h00);
          emitStore();
        end
        3'd4: begin
          case (2'(randProg(2)))
            2'd0:    emit(8'h29);
            2'd1:    emit(8'h09);
            default: emit(8'h49);
          endcase
          emit(8'(randProg(8)));
        end
        3'd5: begin
          case (2'(randProg(2)))
            2'd0:    emit(8'h02);
            2'd1:    emit(8'hFF);
            2'd2:    emit(8'h5B);
            default: emit(8'h80);
          endcase
        end
        3'd6: begin
          gap = 1 + int'(randProg(3));
          target = pcW + 16'd3 + 16'(gap);
          emitAbs(8'h4C, target);
          // filler would store to 5000 if ever executed
          for (int g = 0; g < gap; g++) begin
            case (g % 3)
              0:       emit(8'h8D);
              1:       emit(8'h00);
              default: emit(8'h50);
            endcase
          end
        end
        default: begin
          case (2'(randProg(2)))
            2'd0:    emit(8'h38);
            2'd1:    emit(8'h18);
            default: emit(8'hEA);
          endcase
        end
      endcase
      sinceStore++;
      if (sinceStore >= 3) begin
        emitStore();
        sinceStore = 0;
      end
    end
    emitStore();
    endAddr = pcW;
    emitAbs(8'h4C, endAddr);
    img[16'hFFFC] = progStart[7:0];
    img[16'hFFFD] = progStart[15:8];
  endtask

  // software model of the subset that fills the expected store list
  function automatic void predictStores();
    logic [15:0] pc, target;
    logic [7:0]  a, op, lo, hi;
    int          t;
    logic        c, done;
    pc = progStart;
    a = 8'd0;
    c = 1'b0;
    done = 1'b0;
    for (int steps = 0; steps < 5000 && !done; steps++) begin
      op = img[pc];
      lo = img[pc + 16'd1];
      hi = img[pc + 16'd2];
      target = {hi, lo};
      case (op)
        8'hA9: begin
          a = lo;
          pc = pc + 16'd2;
        end
        8'hAD: begin
          a = img[target];
          pc = pc + 16'd3;
        end
        8'h8D: begin
          expAddr.push_back(target);
          expData.push_back(a);
          pc = pc + 16'd3;
        end
        8'h69: begin
          t = int'(a) + int'(lo) + (c ? 1 : 0);
          a = 8'(t);
          c = t > 255;
          pc = pc + 16'd2;
        end
        8'hE9: begin
          // borrow taken when carry is clear
          t = int'(a) - int'(lo) - (c ? 0 : 1);
          a = 8'(t);
          c = t >= 0;
          pc = pc + 16'd2;
        end
        8'h29: begin
          a = a & lo;
          pc = pc + 16'd2;
        end
        8'h09: begin
          a = a | lo;
          pc = pc + 16'd2;
        end
        8'h49: begin
          a = a ^ lo;
          pc = pc + 16'd2;
        end
        8'h4C: begin
          done = (target == pc);
          pc = target;
        end
        8'h38: begin
          c = 1'b1;
          pc = pc + 16'd1;
        end
        8'h18: begin
          c = 1'b0;
          pc = pc + 16'd1;
        end
        default: pc = pc + 16'd1;
      endcase
    end
  endfunction

  // bus monitor and store compare
  always @(posedge clk) begin
    if (!arstN) begin
      if (wbCyc || sync) begin
        protocolErrors++;
        $display("[ERROR] %0t: wbCyc or sync high during reset", $time);
      end
      accessIdx = 0;
      loopSeen = 1'b0;
      syncPending = 1'b0;
      syncChecked = 1'b0;
      prevStb = 1'b0;
      prevAck = 1'b0;
    end else begin
      if (prevStb && !prevAck && !wbStb) begin
        protocolErrors++;
        $display("[ERROR] %0t: wbStb dropped before ack", $time);
      end
      if (syncPending && !syncChecked) begin
        syncChecked = 1'b1;
        if (wbAdr != progStart) begin
          protocolErrors++;
          $display("[ERROR] %0t: first fetch at %h, expected %h", $time, wbAdr, progStart);
        end
      end
      if (sync) begin
        syncPending = 1'b1;
      end
      if (wbCyc && wbStb && wbAck) begin
        if (accessIdx < 2 && wbAdr != 16'hFFFC + 16'(accessIdx)) begin
          protocolErrors++;
          $display("[ERROR] %0t: vector read %0d at %h", $time, accessIdx, wbAdr);
        end
        accessIdx++;
        if (wbWe) begin
          if (expAddr.size() == 0) begin
            dataErrors++;
            $display("[ERROR] %0t: unexpected store %h=%h", $time, wbAdr, wbDatO);
          end else begin
            if (wbAdr != expAddr[0] || wbDatO != expData[0]) begin
              dataErrors++;
              $display("[ERROR] %0t: store got %h=%h, expected %h=%h", $time,
                       wbAdr, wbDatO, expAddr[0], expData[0]);
            end
            void'(expAddr.pop_front());
            void'(expData.pop_front());
          end
        end else if (wbAdr == endAddr && accessIdx > 2) begin
          loopSeen = 1'b1;
        end
      end
      prevStb = wbStb;
      prevAck = wbAck;
    end
  end

  initial begin
    int waited;
    arstN = 1'b0;
    randomDelays = 1'b0;
    ackDelay = 2'd0;
    progLfsr = 32'h655325f9;
    delayLfsr = 32'h655325f9;
    dataErrors = 0;
    protocolErrors = 0;
    timeouts = 0;
    endAddr = 16'hFFFF;
    // each program runs once without and once with back-pressure
    for (int run = 0; run < 8; run++) begin
      @(posedge clk);
      arstN <= 1'b0;
      randomDelays <= (run % 2) == 1;
      if (run % 2 == 0) begin
        buildProgram();
      end
      for (int i = 0; i < 65536; i++) begin
        memory.mem[i] = img[i];
      end
      expAddr.delete();
      expData.delete();
      predictStores();
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      waited = 0;
      while (!loopSeen && waited < 20000) begin
        @(negedge clk);
        waited++;
      end
      if (!loopSeen) begin
        timeouts++;
        $display("timeout waiting for program %0d to reach its end loop at %h", run, endAddr);
      end else if (expAddr.size() != 0) begin
        dataErrors++;
        $display("[ERROR] %0t: %0d expected stores never seen", $time, expAddr.size());
      end
    end
    $display("errors: data %0d, protocol %0d, timeouts %0d", dataErrors, protocolErrors,
             timeouts);
    if (dataErrors == 0 && protocolErrors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/wbMemoryModel.sv */
// --------------------
// 64 KiB Wishbone classic slave memory for the testbench
// ack comes ackDelay cycles after the strobe, contents loaded by hierarchy
// --------------------
`timescale 1ns/1ps

module wbMemoryModel (
  input  logic        clk,
  input  logic        arstN,
  input  logic [1:0]  ackDelay,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [15:0] wbAdr,
  input  logic [7:0]  wbDatO,
  output logic        wbAck,
  output logic [7:0]  wbDatI
);

  logic [7:0] mem [0:65535];
  logic [1:0] waitCount;

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbAck     <= 1'b0;
      wbDatI    <= 8'd0;
      waitCount <= 2'd0;
    end else begin
      wbAck <= 1'b0;
      // one ack per strobe, then wait for the master to drop it
      if (wbCyc && wbStb && !wbAck) begin
        if (waitCount >= ackDelay) begin
          wbAck     <= 1'b1;
          waitCount <= 2'd0;
          wbDatI    <= mem[wbAdr];
          if (wbWe) begin
            mem[wbAdr] <= wbDatO;
          end
        end else begin
          waitCount <= waitCount + 2'd1;
        end
      end
    end
  end

endmodule
